// ==== hdl/cps2_pkg.sv ====
/* Shared types, memory map and object table sizes of the main CPU bus block.
   RTL and bench files refer to these by scoped names */
package cps2_pkg;

    typedef logic [23:1] cpu_addr_t; // 68000 word address
    typedef logic [15:0] word_t;
    typedef logic [20:0] mem_addr_t; // Word address inside one region
    typedef logic [1:0]  be_t;       // Bit 1 upper byte, bit 0 lower byte

    typedef enum logic [2:0] {
        REG_ROM,
        REG_RAM,
        REG_VRAM,
        REG_ORAM,
        REG_IO,
        REG_NONE
    } region_e;

    typedef enum logic {
        JOY_4BUT, // Four players, four buttons
        JOY_6BUT  // Two players, six buttons
    } joymode_e;

    // Region decode on the top address bits
    localparam logic [1:0] ROM_TOP   = 2'b00;      // A[23:22]
    localparam logic [7:0] RAM_TOP   = 8'hff;      // A[23:16]
    localparam logic [5:0] VRAM_TOP  = 6'b100100;  // A[23:18]
    localparam logic [1:0] VRAM_HOLE = 2'b11;      // A[17:16], not mapped
    localparam logic [3:0] ORAM_TOP  = 4'h7;       // A[23:20]
    localparam logic [4:0] IO_TOP    = 5'b10000;   // A[23:19]

    // Object RAM word address width, the top bit selects the bank
    localparam int ORAM_AW = 13;

    // Byte offsets inside the I/O window
    localparam logic [8:0] IO_IN0   = 9'h000;
    localparam logic [8:0] IO_IN1   = 9'h010;
    localparam logic [8:0] IO_IN2   = 9'h020;
    localparam logic [8:0] IO_OUT   = 9'h040;
    localparam logic [8:0] IO_OBANK = 9'h0e0; // Object base sits 2 bytes above

    // Object table
    localparam int OBJ_WORDS = 16;
    localparam int OBJ_AW    = 4;

endpackage

// ==== hdl/mem_req_if.sv ====
/* Request from one peer to the shared memory port. Fields stay stable
   while req is high, done pulses for one cycle with rdata valid */
interface mem_req_if;

    logic                req;
    cps2_pkg::region_e   region;
    cps2_pkg::mem_addr_t addr;
    logic                we;
    cps2_pkg::be_t       be;
    cps2_pkg::word_t     wdata;
    cps2_pkg::word_t     rdata;
    logic                done;

    modport requester (
        output req, region, addr, we, be, wdata,
        input  rdata, done
    );

    modport arbiter (
        input  req, region, addr, we, be, wdata,
        output rdata, done
    );

endinterface

// ==== hdl/bus_decode.sv ====
/* CPU address strobe decoder. Latches each bus cycle once and turns it into
   a memory request or an I/O select */
module bus_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                as_n,
    input  logic                uds_n,
    input  logic                lds_n,
    input  logic                rnw,
    input  cps2_pkg::cpu_addr_t cpu_addr,
    input  cps2_pkg::word_t     cpu_dout,
    mem_req_if.requester        cpu_req,
    output logic                io_sel,
    output cps2_pkg::cpu_addr_t io_addr,
    output cps2_pkg::be_t       io_be,
    output logic                io_wr,
    input  logic                cycle_end
);

    cps2_pkg::region_e   region;   // From the live address
    cps2_pkg::region_e   region_q;
    logic                latched;  // Bus cycle already taken
    cps2_pkg::cpu_addr_t addr_q;
    cps2_pkg::be_t       be_q;
    logic                we_q;
    cps2_pkg::word_t     wdata_q;

    always_comb begin
        if (cpu_addr[23:22] == cps2_pkg::ROM_TOP) begin
            region = cps2_pkg::REG_ROM;
        end else if (cpu_addr[23:16] == cps2_pkg::RAM_TOP) begin
            region = cps2_pkg::REG_RAM;
        end else if (cpu_addr[23:18] == cps2_pkg::VRAM_TOP &&
                     cpu_addr[17:16] != cps2_pkg::VRAM_HOLE) begin
            region = cps2_pkg::REG_VRAM;
        end else if (cpu_addr[23:20] == cps2_pkg::ORAM_TOP) begin
            region = cps2_pkg::REG_ORAM;
        end else if (cpu_addr[23:19] == cps2_pkg::IO_TOP) begin
            region = cps2_pkg::REG_IO;
        end else begin
            region = cps2_pkg::REG_NONE; // Includes the VRAM hole
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latched     <= 1'b0;
            region_q    <= cps2_pkg::REG_NONE;
            cpu_req.req <= 1'b0;
            io_sel      <= 1'b0;
        end else if (as_n) begin
            latched     <= 1'b0;
            cpu_req.req <= 1'b0;
            io_sel      <= 1'b0;
        end else begin
            if (!latched) begin
                latched     <= 1'b1;
                region_q    <= region;
                // Unmapped cycles go to the arbiter as well, it answers them itself
                cpu_req.req <= region != cps2_pkg::REG_IO;
                io_sel      <= region == cps2_pkg::REG_IO;
            end
            if (cpu_req.done) cpu_req.req <= 1'b0;
            if (cycle_end) io_sel <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!as_n && !latched) begin
            addr_q  <= cpu_addr;
            be_q    <= {~uds_n, ~lds_n};
            we_q    <= ~rnw;
            wdata_q <= cpu_dout;
        end
    end

    always_comb begin
        case (region_q)
            cps2_pkg::REG_ROM:  cpu_req.addr = cps2_pkg::mem_addr_t'(addr_q[21:1]);
            cps2_pkg::REG_RAM:  cpu_req.addr = cps2_pkg::mem_addr_t'(addr_q[15:1]);
            cps2_pkg::REG_VRAM: cpu_req.addr = cps2_pkg::mem_addr_t'(addr_q[17:1]);
            cps2_pkg::REG_ORAM: cpu_req.addr = cps2_pkg::mem_addr_t'(addr_q[cps2_pkg::ORAM_AW:1]);
            default:            cpu_req.addr = '0;
        endcase
    end

    assign cpu_req.region = region_q;
    assign cpu_req.we     = we_q;
    assign cpu_req.be     = be_q;
    assign cpu_req.wdata  = wdata_q;
    assign io_addr        = addr_q;
    assign io_be          = be_q;
    assign io_wr          = we_q;

endmodule

// ==== hdl/io_regs.sv ====
/* Cabinet I/O window. Builds the input words, holds the EEPROM, sound reset
   and object registers, and answers I/O reads one cycle after the select */
module io_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                io_sel,
    input  cps2_pkg::cpu_addr_t io_addr,
    input  cps2_pkg::be_t       io_be,
    input  logic                io_wr,
    input  cps2_pkg::word_t     cpu_dout,
    input  cps2_pkg::joymode_e  joymode,
    input  logic [9:0]          joystick1,
    input  logic [9:0]          joystick2,
    input  logic [9:0]          joystick3,
    input  logic [9:0]          joystick4,
    input  logic [3:0]          start_button,
    input  logic [3:0]          coin_input,
    input  logic                service,
    input  logic                dip_test,
    input  logic                eeprom_sdo,
    output cps2_pkg::word_t     io_rdata,
    output logic                io_done,
    output logic                eeprom_sclk,
    output logic                eeprom_sdi,
    output logic                eeprom_scs,
    output logic                z80_rstn,
    output logic                obank,
    output cps2_pkg::word_t     oram_base,
    output logic                obj_start
);

    cps2_pkg::word_t in0, in1, in2;
    logic [8:0]      off;      // Byte offset in the window
    logic            io_sel_q;
    logic            wr_en;

    assign off   = {io_addr[8:1], 1'b0};
    assign wr_en = io_sel && io_wr && io_done; // Lands with dtack_n

    always_comb begin
        in0 = {joystick2[7:0], joystick1[7:0]};
        in1 = {joystick4[7:0], joystick3[7:0]};
        if (joymode == cps2_pkg::JOY_6BUT) begin
            in1      = 16'hffff; // Extra buttons only
            in1[2:0] = joystick1[9:7];
            in1[5:4] = joystick2[8:7];
        end
        in2 = {coin_input, start_button, 5'b11111, service, dip_test, eeprom_sdo};
    end

    always_ff @(posedge clk) begin
        if (off == cps2_pkg::IO_IN0)      io_rdata <= in0;
        else if (off == cps2_pkg::IO_IN1) io_rdata <= in1;
        else if (off == cps2_pkg::IO_IN2) io_rdata <= in2;
        else                              io_rdata <= 16'hffff;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_sel_q    <= 1'b0;
            io_done     <= 1'b0;
            eeprom_sclk <= 1'b0;
            eeprom_sdi  <= 1'b0;
            eeprom_scs  <= 1'b0;
            z80_rstn    <= 1'b0;
            obank       <= 1'b0;
            oram_base   <= '0;
            obj_start   <= 1'b0;
        end else begin
            io_sel_q  <= io_sel;
            io_done   <= io_sel && !io_sel_q;
            obj_start <= 1'b0;
            if (wr_en && off == cps2_pkg::IO_OUT) begin
                if (io_be[1]) begin
                    eeprom_sdi  <= cpu_dout[12];
                    eeprom_sclk <= cpu_dout[13];
                    eeprom_scs  <= cpu_dout[14];
                end
                if (io_be[0]) z80_rstn <= cpu_dout[3];
            end
            if (wr_en && off == cps2_pkg::IO_OBANK && io_be[0]) begin
                obank     <= cpu_dout[0];
                obj_start <= 1'b1; // Kicks off the table copy
            end
            if (wr_en && off == cps2_pkg::IO_OBANK + 9'd2) begin
                if (io_be[1]) oram_base[15:8] <= cpu_dout[15:8];
                if (io_be[0]) oram_base[7:0]  <= cpu_dout[7:0];
            end
        end
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
/* Shares the external memory port between the CPU and the object DMA.
   Also closes every CPU bus cycle with cpu_din and dtack_n */
module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    mem_req_if.arbiter          cpu_req,
    mem_req_if.arbiter          dma_req,
    input  logic                io_sel,
    input  logic                io_done,
    input  cps2_pkg::word_t     io_rdata,
    input  logic                as_n,
    output logic                mem_cs,
    output cps2_pkg::region_e   mem_region,
    output cps2_pkg::mem_addr_t mem_addr,
    output logic                mem_we,
    output cps2_pkg::be_t       mem_be,
    output cps2_pkg::word_t     mem_wdata,
    input  cps2_pkg::word_t     mem_data,
    input  logic                mem_ok,
    output cps2_pkg::word_t     cpu_din,
    output logic                dtack_n,
    output logic                cycle_end
);

    typedef enum logic [1:0] {IDLE, CPU_ACC, DMA_ACC, ACK} state_e;

    state_e state;
    logic   cpu_none; // Unmapped, answered without the memory
    logic   cpu_done;
    logic   cpu_fin;  // Any CPU cycle finishing

    assign cpu_none = cpu_req.region == cps2_pkg::REG_NONE;
    assign cpu_done = state == CPU_ACC && (cpu_none || mem_ok);
    assign cpu_fin  = cpu_done || (io_sel && io_done);

    assign cpu_req.done  = cpu_done;
    assign cpu_req.rdata = mem_data;
    assign dma_req.done  = state == DMA_ACC && mem_ok;
    assign dma_req.rdata = mem_data;

    // Port follows the granted peer
    assign mem_cs     = (state == CPU_ACC && !cpu_none) || state == DMA_ACC;
    assign mem_region = (state == DMA_ACC) ? dma_req.region : cpu_req.region;
    assign mem_addr   = (state == DMA_ACC) ? dma_req.addr   : cpu_req.addr;
    assign mem_we     = (state == DMA_ACC) ? dma_req.we     : cpu_req.we;
    assign mem_be     = (state == DMA_ACC) ? dma_req.be     : cpu_req.be;
    assign mem_wdata  = (state == DMA_ACC) ? dma_req.wdata  : cpu_req.wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req.req)      state <= CPU_ACC; // CPU wins ties
                    else if (dma_req.req) state <= DMA_ACC;
                end
                CPU_ACC: if (cpu_done) state <= ACK;
                DMA_ACC: if (mem_ok) state <= IDLE;
                ACK:     if (as_n) state <= IDLE; // Hold until the CPU lets go
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_n   <= 1'b1;
            cycle_end <= 1'b0;
        end else begin
            cycle_end <= cpu_fin;
            if (cpu_fin)   dtack_n <= 1'b0;
            else if (as_n) dtack_n <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (io_sel && io_done) cpu_din <= io_rdata;
        else if (cpu_done)     cpu_din <= cpu_none ? 16'hffff : mem_data;
    end

endmodule

// ==== hdl/obj_dma.sv ====
/* Object table copy engine. A bank write starts a read of OBJ_WORDS words
   from object RAM, one request in flight, streamed out with their index */
module obj_dma (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          obj_start,
    input  logic                          obank,
    mem_req_if.requester                  dma_req,
    output cps2_pkg::word_t               obj_data,
    output logic [cps2_pkg::OBJ_AW-1:0]   obj_index,
    output logic                          obj_valid
);

    localparam int PAD = cps2_pkg::ORAM_AW - 1 - cps2_pkg::OBJ_AW;

    logic                        active; // Copy running
    logic                        bank;
    logic [cps2_pkg::OBJ_AW-1:0] idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active      <= 1'b0;
            bank        <= 1'b0;
            idx         <= '0;
            dma_req.req <= 1'b0;
            obj_valid   <= 1'b0;
        end else begin
            obj_valid <= dma_req.done;
            if (!active) begin
                if (obj_start) begin // Ignored while a copy runs
                    active      <= 1'b1;
                    bank        <= obank;
                    idx         <= '0;
                    dma_req.req <= 1'b1;
                end
            end else if (dma_req.done) begin
                dma_req.req <= 1'b0;
                if (idx == cps2_pkg::OBJ_AW'(cps2_pkg::OBJ_WORDS - 1)) active <= 1'b0;
                else idx <= idx + 1'b1;
            end else if (!dma_req.req) begin
                dma_req.req <= 1'b1; // Next word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dma_req.done) begin
            obj_data  <= dma_req.rdata;
            obj_index <= idx;
        end
    end

    assign dma_req.region = cps2_pkg::REG_ORAM;
    assign dma_req.addr   = cps2_pkg::mem_addr_t'({bank, {PAD{1'b0}}, idx});
    assign dma_req.we     = 1'b0;
    assign dma_req.be     = 2'b11;
    assign dma_req.wdata  = '0;

endmodule

// ==== hdl/cps2_main_bus.sv ====
/* Main CPU bus block top. The CPU bus, cabinet pins, shared memory port
   and object stream are plain ports */
module cps2_main_bus (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          as_n,
    input  logic                          uds_n,
    input  logic                          lds_n,
    input  logic                          rnw,
    input  cps2_pkg::cpu_addr_t           cpu_addr,
    input  cps2_pkg::word_t               cpu_dout,
    output cps2_pkg::word_t               cpu_din,
    output logic                          dtack_n,
    input  cps2_pkg::joymode_e            joymode,
    input  logic [9:0]                    joystick1,
    input  logic [9:0]                    joystick2,
    input  logic [9:0]                    joystick3,
    input  logic [9:0]                    joystick4,
    input  logic [3:0]                    start_button,
    input  logic [3:0]                    coin_input,
    input  logic                          service,
    input  logic                          dip_test,
    input  logic                          eeprom_sdo,
    output logic                          eeprom_sclk,
    output logic                          eeprom_sdi,
    output logic                          eeprom_scs,
    output logic                          z80_rstn,
    output logic                          obank,
    output cps2_pkg::word_t               oram_base,
    output logic                          mem_cs,
    output cps2_pkg::region_e             mem_region,
    output cps2_pkg::mem_addr_t           mem_addr,
    output logic                          mem_we,
    output cps2_pkg::be_t                 mem_be,
    output cps2_pkg::word_t               mem_wdata,
    input  cps2_pkg::word_t               mem_data,
    input  logic                          mem_ok,
    output cps2_pkg::word_t               obj_data,
    output logic [cps2_pkg::OBJ_AW-1:0]   obj_index,
    output logic                          obj_valid
);

    logic                io_sel;
    cps2_pkg::cpu_addr_t io_addr;
    cps2_pkg::be_t       io_be;
    logic                io_wr;
    cps2_pkg::word_t     io_rdata;
    logic                io_done;
    logic                cycle_end;
    logic                obj_start;

    mem_req_if cpu_req ();
    mem_req_if dma_req ();

    bus_decode bus_decode_inst (
        .clk, .rst, .as_n, .uds_n, .lds_n, .rnw, .cpu_addr, .cpu_dout,
        .cpu_req, .io_sel, .io_addr, .io_be, .io_wr, .cycle_end
    );

    io_regs io_regs_inst (
        .clk, .rst, .io_sel, .io_addr, .io_be, .io_wr, .cpu_dout, .joymode,
        .joystick1, .joystick2, .joystick3, .joystick4, .start_button, .coin_input,
        .service, .dip_test, .eeprom_sdo, .io_rdata, .io_done, .eeprom_sclk,
        .eeprom_sdi, .eeprom_scs, .z80_rstn, .obank, .oram_base, .obj_start
    );

    mem_arbiter mem_arbiter_inst (
        .clk, .rst, .cpu_req, .dma_req, .io_sel, .io_done, .io_rdata, .as_n,
        .mem_cs, .mem_region, .mem_addr, .mem_we, .mem_be, .mem_wdata,
        .mem_data, .mem_ok, .cpu_din, .dtack_n, .cycle_end
    );

    obj_dma obj_dma_inst (
        .clk, .rst, .obj_start, .obank, .dma_req, .obj_data, .obj_index, .obj_valid
    );

endmodule

// ==== bench/main_bus_tb.sv ====
/* Testbench for the main CPU bus block. Acts as the 68000 and the shared memory,
   and replays the operations and object stream listed in main_bus_golden.txt */
module main_bus_tb;

    logic                            clk;
    logic                            rst;
    logic                            as_n, uds_n, lds_n, rnw;
    cps2_pkg::cpu_addr_t             cpu_addr;
    cps2_pkg::word_t                 cpu_dout, cpu_din;
    logic                            dtack_n;
    cps2_pkg::joymode_e              joymode;
    logic [9:0]                      joystick1, joystick2, joystick3, joystick4;
    logic [3:0]                      start_button, coin_input;
    logic                            service, dip_test, eeprom_sdo;
    logic                            eeprom_sclk, eeprom_sdi, eeprom_scs, z80_rstn, obank;
    cps2_pkg::word_t                 oram_base;
    logic                            mem_cs, mem_we, mem_ok;
    cps2_pkg::region_e               mem_region;
    cps2_pkg::mem_addr_t             mem_addr;
    cps2_pkg::be_t                   mem_be;
    cps2_pkg::word_t                 mem_wdata, mem_data;
    cps2_pkg::word_t                 obj_data;
    logic [cps2_pkg::OBJ_AW-1:0]     obj_index;
    logic                            obj_valid;

    cps2_pkg::word_t                 mem_store [logic [23:0]]; // Key is region and address
    byte                             kinds[$];                 // One per golden step
    logic [31:0]                     fields[$];                // Ten per step
    logic [cps2_pkg::OBJ_AW+15:0]    obj_exp[$];               // Index and word
    logic [cps2_pkg::OBJ_AW+15:0]    obj_next;
    int                              errors = 0;
    int                              n_ops = 0;
    int                              cycle_count = 0;
    int                              cycle_limit = 0;

    cps2_main_bus cps2_main_bus_inst (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timed out after %0d cycles, the DUT stopped answering", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_word(input cps2_pkg::word_t got, input cps2_pkg::word_t exp_word,
                              input string what);
        if (got !== exp_word) begin
            $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp_word);
            errors++;
        end
    endtask

    task automatic check_pin(input logic got, input logic exp_bit, input string what);
        if (got !== exp_bit) begin
            $display("ERR %0t: %s got %b, expected %b", $time, what, got, exp_bit);
            errors++;
        end
    endtask

    task automatic check_obj(input logic [cps2_pkg::OBJ_AW-1:0] idx, input cps2_pkg::word_t data,
                             input logic [cps2_pkg::OBJ_AW+15:0] exp_obj);
        if (idx !== exp_obj[cps2_pkg::OBJ_AW+15:16] || data !== exp_obj[15:0]) begin
            $display("ERR %0t: object word got %0d:%h, expected %0d:%h", $time, idx, data,
                     exp_obj[cps2_pkg::OBJ_AW+15:16], exp_obj[15:0]);
            errors++;
        end
    endtask

    // Unwritten words read as address XOR region code in bits 15..13
    function automatic cps2_pkg::word_t model_read(input logic [23:0] key);
        if (mem_store.exists(key)) return mem_store[key];
        return key[15:0] ^ {key[23:21], 13'b0};
    endfunction

    // I/O and unmapped cycles never touch the memory port
    function automatic logic answered_locally(input logic [23:0] a);
        logic in_mem;
        in_mem = a[23:22] == cps2_pkg::ROM_TOP || a[23:16] == cps2_pkg::RAM_TOP ||
                 (a[23:18] == cps2_pkg::VRAM_TOP && a[17:16] != cps2_pkg::VRAM_HOLE) ||
                 a[23:20] == cps2_pkg::ORAM_TOP;
        return !in_mem;
    endfunction

    task automatic load_golden();
        int          fd, c, k, nf, r;
        logic [31:0] v, first;
        fd = $fopen("bench/main_bus_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/main_bus_golden.txt");
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                case (c)
                    "M":      nf = 10;
                    "R", "W": nf = 4;
                    "P":      nf = 6;
                    default:  nf = 0;
                endcase
                if (c == "#") begin
                    while (c != "\n" && c != -1) c = $fgetc(fd);
                end else if (c == "O") begin
                    r = $fscanf(fd, "%h", first);
                    for (k = 0; k < 8; k++) begin
                        r = $fscanf(fd, "%h", v);
                        obj_exp.push_back({first[cps2_pkg::OBJ_AW-1:0] + k[3:0], v[15:0]});
                    end
                end else if (nf != 0) begin
                    kinds.push_back(byte'(c));
                    for (k = 0; k < 10; k++) begin
                        v = '0;
                        if (k < nf) r = $fscanf(fd, "%h", v);
                        fields.push_back(v);
                    end
                    if (c == "R" || c == "W") n_ops++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // One 68000 bus cycle that starts and ends 1 time unit after a rising edge
    task automatic bus_cycle(input logic wr, input logic [23:0] baddr, input cps2_pkg::be_t be,
                             input cps2_pkg::word_t wdata, input cps2_pkg::word_t exp_data);
        int edges;
        cpu_addr = baddr[23:1];
        uds_n    = !be[1];
        lds_n    = !be[0];
        rnw      = !wr;
        cpu_dout = wdata;
        as_n     = 1'b0;
        edges    = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (dtack_n);
        if (!wr) check_word(cpu_din, exp_data, $sformatf("read of %h", baddr));
        if (answered_locally(baddr))
            check_pin(logic'(edges == 3), 1'b1, $sformatf("dtack_n timing at %h", baddr));
        as_n = 1'b1;
        while (!dtack_n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : memory_model
        int              delay;
        logic [23:0]     key;
        cps2_pkg::word_t word;
        delay    = $urandom(32'h3dbb_54ab);
        mem_ok   = 1'b0;
        mem_data = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ok = 1'b0;
            if (mem_cs) begin
                delay = $urandom % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                key  = {mem_region, mem_addr};
                word = model_read(key);
                if (mem_we) begin
                    if (mem_be[1]) word[15:8] = mem_wdata[15:8];
                    if (mem_be[0]) word[7:0] = mem_wdata[7:0];
                    mem_store[key] = word;
                end
                mem_data = word;
                mem_ok   = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && obj_valid) begin
            if (obj_exp.size() == 0) begin
                $display("Object word %0d arrived after the whole table was seen", obj_index);
                errors++;
            end else begin
                obj_next = obj_exp.pop_front();
                check_obj(obj_index, obj_data, obj_next);
            end
        end
    end

    initial begin
        int          i, k;
        logic [31:0] f [0:9];
        rst          = 1'b1;
        as_n         = 1'b1;
        uds_n        = 1'b1;
        lds_n        = 1'b1;
        rnw          = 1'b1;
        cpu_addr     = '0;
        cpu_dout     = '0;
        joymode      = cps2_pkg::JOY_4BUT;
        joystick1    = '0;
        joystick2    = '0;
        joystick3    = '0;
        joystick4    = '0;
        start_button = '0;
        coin_input   = '0;
        service      = 1'b0;
        dip_test     = 1'b0;
        eeprom_sdo   = 1'b0;
        load_golden();
        cycle_limit = n_ops * 40 + 200;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_pin(dtack_n, 1'b1, "dtack_n after reset");
        check_pin(mem_cs, 1'b0, "mem_cs after reset");
        check_pin(obj_valid, 1'b0, "obj_valid after reset");
        check_pin(eeprom_sdi, 1'b0, "eeprom_sdi after reset");
        check_pin(eeprom_sclk, 1'b0, "eeprom_sclk after reset");
        check_pin(eeprom_scs, 1'b0, "eeprom_scs after reset");
        check_pin(z80_rstn, 1'b0, "z80_rstn after reset");
        check_word(oram_base, 16'h0000, "oram_base after reset");
        for (i = 0; i < kinds.size(); i++) begin
            for (k = 0; k < 10; k++) f[k] = fields[i * 10 + k];
            case (kinds[i])
                "M": begin // Cabinet inputs
                    joymode      = cps2_pkg::joymode_e'(f[0][0]);
                    joystick1    = f[1][9:0];
                    joystick2    = f[2][9:0];
                    joystick3    = f[3][9:0];
                    joystick4    = f[4][9:0];
                    coin_input   = f[5][3:0];
                    start_button = f[6][3:0];
                    service      = f[7][0];
                    dip_test     = f[8][0];
                    eeprom_sdo   = f[9][0];
                end
                "R", "W": bus_cycle(kinds[i] == "W", f[0][23:0], f[1][1:0], f[2][15:0],
                                    f[3][15:0]);
                "P": begin
                    check_pin(eeprom_sdi, f[0][0], "eeprom_sdi");
                    check_pin(eeprom_sclk, f[1][0], "eeprom_sclk");
                    check_pin(eeprom_scs, f[2][0], "eeprom_scs");
                    check_pin(z80_rstn, f[3][0], "z80_rstn");
                    check_pin(obank, f[4][0], "obank");
                    check_word(oram_base, f[5][15:0], "oram_base");
                end
                default: ;
            endcase
        end
        while (obj_exp.size() != 0) @(posedge clk); // Rest of the table copy
        repeat (8) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== bench/main_bus_golden.txt ====
# M joymode joy1 joy2 joy3 joy4 coin start service dip_test eeprom_sdo | P sdi sclk scs z80_rstn obank oram_base
# R/W byte_addr byte_enables wdata expected_rdata (ignored for W) | O first_index then 8 object words
M 0 2a5 13c 0f1 38e 5 a 1 0 1
R 000100 3 0000 0080
R 12345a 3 0000 1a2d
R ff1234 3 0000 291a
R 900040 3 0000 4020
R 92abcc 3 0000 15e6
R 700020 3 0000 6010
R 930000 3 0000 ffff
R c00000 3 0000 ffff
W ff1234 1 abcd 0000
R ff1234 3 0000 29cd
W ff1236 2 5a00 0000
R ff1236 3 0000 5a1b
R 804000 3 0000 3ca5
R 804010 3 0000 8ef1
R 804020 3 0000 5afd
R 804030 3 0000 ffff
M 1 2c3 155 000 3ff f 0 0 1 0
R 804000 3 0000 55c3
R 804010 3 0000 ffed
R 804020 3 0000 f0fa
W 804040 3 5008 0000
P 1 0 1 1 0 0000
W 804040 2 2000 0000
P 0 1 0 1 0 0000
W 8040e2 3 7080 0000
W 702006 3 beef 0000
W 702014 2 1200 0000
W 8040e0 1 0001 0000
P 0 1 0 1 1 7080
R ff1234 3 0000 29cd
R 702006 3 0000 beef
R 702014 3 0000 120a
R 92abcc 3 0000 15e6
O 0 7000 7001 7002 beef 7004 7005 7006 7007
O 8 7008 7009 120a 700b 700c 700d 700e 700f

// ==== compile.f ====
hdl/cps2_pkg.sv
hdl/mem_req_if.sv
hdl/bus_decode.sv
hdl/io_regs.sv
hdl/mem_arbiter.sv
hdl/obj_dma.sv
hdl/cps2_main_bus.sv
bench/main_bus_tb.sv

// ==== Bender.yml ====
package:
  name: cps2_main_bus

sources:
  - files:
      - hdl/cps2_pkg.sv
      - hdl/mem_req_if.sv
      - hdl/bus_decode.sv
      - hdl/io_regs.sv
      - hdl/mem_arbiter.sv
      - hdl/obj_dma.sv
      - hdl/cps2_main_bus.sv
  - target: test
    files:
      - bench/main_bus_tb.sv
